//--- Bender.yml
package:
  name: chip_mem

sources:
  - logic/mem_pkg.sv
  - logic/axi_lite_if.sv
  - logic/ram_port_if.sv
  - logic/mem_decoder.sv
  - logic/bram_ctrl.sv
  - logic/bram_array.sv
  - logic/chip_mem_top.sv
  - target: test
    files:
      - bench/tb_chip_mem.sv

//--- bench/tb_chip_mem.sv
// chip memory path testbench with clock, reset, stimulus table, response checks and timeout
module tb_chip_mem import mem_pkg::*;;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int                    num_entries = 16;
   localparam int                    max_cycles  = num_entries * 8 + 20;
   localparam logic [addr_width-1:0] base        = 32'h8000_0000;

   typedef struct packed {
      logic                  is_write;
      logic [addr_width-1:0] addr;
      logic [id_width-1:0]   id;
      logic [data_width-1:0] data;
      logic [strb_width-1:0] strb;
      logic [data_width-1:0] exp_data;
      resp_e                 exp_resp;
   } entry_t;

   logic                  mig_clk;
   logic                  rst_n;
   logic                  aw_valid, aw_ready;
   logic [addr_width-1:0] aw_addr;
   logic [id_width-1:0]   aw_id;
   logic                  w_valid, w_ready;
   logic [data_width-1:0] w_data;
   logic [strb_width-1:0] w_strb;
   logic                  b_valid, b_ready;
   resp_e                 b_resp;
   logic [id_width-1:0]   b_id;
   logic                  ar_valid, ar_ready;
   logic [addr_width-1:0] ar_addr;
   logic [id_width-1:0]   ar_id;
   logic                  r_valid, r_ready;
   logic [data_width-1:0] r_data;
   resp_e                 r_resp;
   logic [id_width-1:0]   r_id;

   entry_t stim [num_entries];
   int     errors = 0;
   int     cycle_count = 0;

   chip_mem_top UUT (.*);

   initial begin
      mig_clk = 1'b0;
      forever #50 mig_clk = ~mig_clk;
   end

   // hang guard
   always @(posedge mig_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("timeout after %0d cycles, the run hung waiting on the DUT", cycle_count);
         $display("Test failed");
         $fatal(1, "simulation hung");
      end
   end

   task automatic check_value(input string what, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // byte lanes with a strobe bit take the new word
   function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old_word,
                                                          input logic [data_width-1:0] new_word,
                                                          input logic [strb_width-1:0] strb);
      logic [data_width-1:0] res;
      res = old_word;
      for (int i = 0; i < strb_width; i++) begin
         if (strb[i])
            res[i*8 +: 8] = new_word[i*8 +: 8];
      end
      return res;
   endfunction

   function automatic entry_t make_entry(input logic is_write, input logic [addr_width-1:0] addr,
                                         input logic [id_width-1:0] id,
                                         input logic [data_width-1:0] data,
                                         input logic [strb_width-1:0] strb,
                                         input logic [data_width-1:0] exp_data,
                                         input resp_e exp_resp);
      entry_t e;
      e = '{is_write, addr, id, data, strb, exp_data, exp_resp};
      return e;
   endfunction

   task automatic fill_table();
      logic [data_width-1:0] merged;
      // boot image words
      stim[0]  = make_entry(0, base + 'h00, 4'h1, '0, '0, 64'h0, resp_okay);
      stim[1]  = make_entry(0, base + 'h08, 4'h2, '0, '0, 64'h1, resp_okay);
      stim[2]  = make_entry(0, base + 'h10, 4'h3, '0, '0, 64'h2, resp_okay);
      stim[3]  = make_entry(0, base + 'h18, 4'h4, '0, '0, 64'h3, resp_okay);
      // two full writes, then read both back
      stim[4]  = make_entry(1, base + 'h40, 4'h5, 64'h0123_4567_89ab_cdef, 8'hff, '0, resp_okay);
      stim[5]  = make_entry(1, base + 'h48, 4'h6, 64'hfedc_ba98_7654_3210, 8'hff, '0, resp_okay);
      stim[6]  = make_entry(0, base + 'h40, 4'h7, '0, '0, stim[4].data, resp_okay);
      stim[7]  = make_entry(0, base + 'h48, 4'h8, '0, '0, stim[5].data, resp_okay);
      // partial strobe
      stim[8]  = make_entry(1, base + 'h40, 4'h9, 64'ha5a5_a5a5_a5a5_a5a5, 8'h35, '0, resp_okay);
      merged   = merge_bytes(stim[4].data, stim[8].data, stim[8].strb);
      stim[9]  = make_entry(0, base + 'h40, 4'ha, '0, '0, merged, resp_okay);
      // outside the window
      stim[10] = make_entry(1, 32'h9000_0000, 4'hb, 64'hdead_beef_dead_beef, 8'hff, '0,
                            resp_decerr);
      stim[11] = make_entry(0, base + 'h1000, 4'hc, '0, '0, 64'h0, resp_decerr);
      stim[12] = make_entry(0, base + 'h00, 4'hd, '0, '0, 64'h0, resp_okay);
      stim[13] = make_entry(0, base + 'h78, 4'he, '0, '0, 64'hf, resp_okay);
      // last word of the window
      stim[14] = make_entry(1, base + 'hff8, 4'hf, 64'h5a5a_0f0f_3c3c_c3c3, 8'hff, '0, resp_okay);
      stim[15] = make_entry(0, base + 'hff8, 4'h0, '0, '0, stim[14].data, resp_okay);
   endtask

   task automatic check_response(input entry_t e);
      if (e.is_write) begin
         check_value("b_valid", b_valid, 1'b1);
         check_value("b_resp", b_resp, e.exp_resp);
         check_value("b_id", b_id, e.id);
         check_value("r_valid during write", r_valid, 1'b0);
      end else begin
         check_value("r_valid", r_valid, 1'b1);
         check_value("r_resp", r_resp, e.exp_resp);
         check_value("r_id", r_id, e.id);
         check_value("r_data", r_data, e.exp_data);
         check_value("b_valid during read", b_valid, 1'b0);
      end
      check_value("aw_ready while pending", aw_ready, 1'b0);
      check_value("w_ready while pending", w_ready, 1'b0);
      check_value("ar_ready while pending", ar_ready, 1'b0);
   endtask

   task automatic run_entry(input int idx);
      entry_t e;
      int     stall;
      int     k;
      e = stim[idx];
      stall = $urandom % 4;
      @(posedge mig_clk);
      if (e.is_write) begin
         aw_valid <= 1'b1;
         aw_addr  <= e.addr;
         aw_id    <= e.id;
         w_valid  <= 1'b1;
         w_data   <= e.data;
         w_strb   <= e.strb;
      end else begin
         ar_valid <= 1'b1;
         ar_addr  <= e.addr;
         ar_id    <= e.id;
      end
      @(negedge mig_clk);
      check_value("b_valid before accept", b_valid, 1'b0);
      check_value("r_valid before accept", r_valid, 1'b0);
      while (!(e.is_write ? (aw_ready && w_ready) : ar_ready)) begin
         @(posedge mig_clk);
         @(negedge mig_clk);
      end
      @(posedge mig_clk);                      // accept edge
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      ar_valid <= 1'b0;
      b_ready  <= e.is_write && stall == 0;
      r_ready  <= !e.is_write && stall == 0;
      for (k = 0; k <= stall; k++) begin
         @(negedge mig_clk);
         check_response(e);
         @(posedge mig_clk);
         b_ready <= e.is_write && (k + 1 == stall);
         r_ready <= !e.is_write && (k + 1 == stall);
      end
   endtask

   initial begin
      int seed;
      seed = $urandom(70);
      rst_n    = 1'b0;
      aw_valid = 1'b0;
      aw_addr  = '0;
      aw_id    = '0;
      w_valid  = 1'b0;
      w_data   = '0;
      w_strb   = '0;
      b_ready  = 1'b0;
      ar_valid = 1'b0;
      ar_addr  = '0;
      ar_id    = '0;
      r_ready  = 1'b0;
      fill_table();
      repeat (4) @(posedge mig_clk);
      rst_n <= 1'b1;
      repeat (3) @(posedge mig_clk);          // reset synchronizer release
      @(negedge mig_clk);
      check_value("b_valid after reset", b_valid, 1'b0);
      check_value("r_valid after reset", r_valid, 1'b0);
      check_value("aw_ready after reset", aw_ready, 1'b1);
      check_value("ar_ready after reset", ar_ready, 1'b1);
      for (int i = 0; i < num_entries; i++)
         run_entry(i);
      @(negedge mig_clk);
      check_value("b_valid at end", b_valid, 1'b0);
      check_value("r_valid at end", r_valid, 1'b0);
      if (errors == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1, "%0d checks failed", errors);
      end
   end

endmodule

//--- boot.mem
// one 64-bit word per line, word i holds i in its low byte
0000000000000000
0000000000000001
0000000000000002
0000000000000003
0000000000000004
0000000000000005
0000000000000006
0000000000000007
0000000000000008
0000000000000009
000000000000000a
000000000000000b
000000000000000c
000000000000000d
000000000000000e
000000000000000f

//--- logic/axi_lite_if.sv
// one-beat aw, w, b, ar and r channels between decoder and bram controller
interface axi_lite_if import mem_pkg::*; #(
   parameter int bram_addr_width = bram_addr_width_def
);

   logic                       aw_valid;
   logic                       aw_ready;
   logic [bram_addr_width-1:0] aw_addr;     // already trimmed to the window
   logic [id_width-1:0]        aw_id;

   logic                       w_valid;
   logic                       w_ready;
   logic [data_width-1:0]      w_data;
   logic [strb_width-1:0]      w_strb;

   logic                       b_valid;
   logic                       b_ready;
   resp_e                      b_resp;
   logic [id_width-1:0]        b_id;

   logic                       ar_valid;
   logic                       ar_ready;
   logic [bram_addr_width-1:0] ar_addr;
   logic [id_width-1:0]        ar_id;

   logic                       r_valid;
   logic                       r_ready;
   logic [data_width-1:0]      r_data;
   resp_e                      r_resp;
   logic [id_width-1:0]        r_id;

   modport master (
      output aw_valid, aw_addr, aw_id, w_valid, w_data, w_strb, b_ready,
      output ar_valid, ar_addr, ar_id, r_ready,
      input  aw_ready, w_ready, b_valid, b_resp, b_id,
      input  ar_ready, r_valid, r_data, r_resp, r_id
   );

   modport slave (
      input  aw_valid, aw_addr, aw_id, w_valid, w_data, w_strb, b_ready,
      input  ar_valid, ar_addr, ar_id, r_ready,
      output aw_ready, w_ready, b_valid, b_resp, b_id,
      output ar_ready, r_valid, r_data, r_resp, r_id
   );

endinterface

//--- logic/bram_array.sv
// byte-enabled inferred ram with registered read address and boot image preload
module bram_array import mem_pkg::*; #(
   parameter int bram_addr_width = bram_addr_width_def
) (
   input  logic     mig_clk,
   ram_port_if.mem  ram
);

   localparam int off_bits = $clog2(strb_width);   // byte offset within a word
   localparam int words    = 2 ** (bram_addr_width - off_bits);

   logic [data_width-1:0]               mem [0:words-1];
   logic [bram_addr_width-1:off_bits]   addr_q;

   always_ff @(posedge mig_clk) begin
      if (ram.en) begin
         addr_q <= ram.addr[bram_addr_width-1:off_bits];
         for (int i = 0; i < strb_width; i++) begin
            if (ram.we[i])
               mem[ram.addr[bram_addr_width-1:off_bits]][i*8 +: 8] <= ram.wrdata[i*8 +: 8];
         end
      end
   end

   assign ram.rddata = mem[addr_q];

   initial begin
      $readmemh("boot.mem", mem);
   end

endmodule

//--- logic/bram_ctrl.sv
// bus to block ram strobe controller for one transaction at a time
module bram_ctrl import mem_pkg::*; #(
   parameter int bram_addr_width = bram_addr_width_def
) (
   input  logic       mig_clk,
   input  logic       rst_n,
   axi_lite_if.slave  bus,
   ram_port_if.ctrl   ram
);

   ctrl_state_e                state;
   logic                       idle;
   logic                       wr_acc, rd_acc;
   logic [bram_addr_width-1:0] req_addr;
   logic [id_width-1:0]        id_q;

   assign idle = state == st_idle;

   // both write halves must be there before either ready goes out
   assign bus.aw_ready = idle && !(bus.aw_valid ^ bus.w_valid);
   assign bus.w_ready  = bus.aw_ready;
   assign bus.ar_ready = idle && !(bus.aw_valid && bus.w_valid);

   assign wr_acc = bus.aw_valid && bus.w_valid && bus.aw_ready;
   assign rd_acc = bus.ar_valid && bus.ar_ready;

   assign req_addr   = wr_acc ? bus.aw_addr : bus.ar_addr;
   assign ram.en     = wr_acc || rd_acc;    // low while waiting, rddata holds
   assign ram.we     = wr_acc ? bus.w_strb : '0;
   assign ram.addr   = req_addr;
   assign ram.wrdata = bus.w_data;

   always_ff @(posedge mig_clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (wr_acc)
                  state <= st_wresp;
               else if (rd_acc)
                  state <= st_rdata;
            end
            st_wresp: begin
               if (bus.b_ready)
                  state <= st_idle;
            end
            st_rdata: begin
               if (bus.r_ready)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // id of the accepted request
   always_ff @(posedge mig_clk) begin
      if (wr_acc)
         id_q <= bus.aw_id;
      else if (rd_acc)
         id_q <= bus.ar_id;
   end

   assign bus.b_valid = state == st_wresp;
   assign bus.b_resp  = resp_okay;
   assign bus.b_id    = id_q;

   assign bus.r_valid = state == st_rdata;
   assign bus.r_data  = ram.rddata;         // from the address registered at accept
   assign bus.r_resp  = resp_okay;
   assign bus.r_id    = id_q;

endmodule

//--- logic/chip_mem_top.sv
// reset synchronizer, address decoder, bram controller and array
module chip_mem_top import mem_pkg::*; #(
   parameter int                    bram_addr_width = bram_addr_width_def,
   parameter logic [addr_width-1:0] bram_base       = bram_base_def
) (
   input  logic                  mig_clk,
   input  logic                  rst_n,
   input  logic                  aw_valid,
   output logic                  aw_ready,
   input  logic [addr_width-1:0] aw_addr,
   input  logic [id_width-1:0]   aw_id,
   input  logic                  w_valid,
   output logic                  w_ready,
   input  logic [data_width-1:0] w_data,
   input  logic [strb_width-1:0] w_strb,
   output logic                  b_valid,
   input  logic                  b_ready,
   output resp_e                 b_resp,
   output logic [id_width-1:0]   b_id,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   input  logic [addr_width-1:0] ar_addr,
   input  logic [id_width-1:0]   ar_id,
   output logic                  r_valid,
   input  logic                  r_ready,
   output logic [data_width-1:0] r_data,
   output resp_e                 r_resp,
   output logic [id_width-1:0]   r_id
);

   logic [1:0] rst_sync;
   logic       mig_rst_n;

   // async assert, release after two mig_clk edges
   always_ff @(posedge mig_clk or negedge rst_n) begin
      if (!rst_n)
         rst_sync <= 2'b00;
      else
         rst_sync <= {rst_sync[0], 1'b1};
   end

   assign mig_rst_n = rst_sync[1];

   axi_lite_if #(.bram_addr_width(bram_addr_width)) bram_bus ();
   ram_port_if #(.bram_addr_width(bram_addr_width)) ram_port ();

   mem_decoder #(
      .bram_addr_width (bram_addr_width),
      .bram_base       (bram_base)
   ) decoder (
      .mig_clk  (mig_clk),
      .rst_n    (mig_rst_n),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .aw_addr  (aw_addr),
      .aw_id    (aw_id),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .w_data   (w_data),
      .w_strb   (w_strb),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .b_resp   (b_resp),
      .b_id     (b_id),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .ar_addr  (ar_addr),
      .ar_id    (ar_id),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .r_data   (r_data),
      .r_resp   (r_resp),
      .r_id     (r_id),
      .bus      (bram_bus.master)
   );

   bram_ctrl #(.bram_addr_width(bram_addr_width)) ctrl (
      .mig_clk (mig_clk),
      .rst_n   (mig_rst_n),
      .bus     (bram_bus.slave),
      .ram     (ram_port.ctrl)
   );

   bram_array #(.bram_addr_width(bram_addr_width)) ram (
      .mig_clk (mig_clk),
      .ram     (ram_port.mem)
   );

endmodule

//--- logic/mem_decoder.sv
// bram window decode, hit forwarding and decode-error responses for misses
module mem_decoder import mem_pkg::*; #(
   parameter int                    bram_addr_width = bram_addr_width_def,
   parameter logic [addr_width-1:0] bram_base       = bram_base_def
) (
   input  logic                  mig_clk,
   input  logic                  rst_n,
   input  logic                  aw_valid,
   output logic                  aw_ready,
   input  logic [addr_width-1:0] aw_addr,
   input  logic [id_width-1:0]   aw_id,
   input  logic                  w_valid,
   output logic                  w_ready,
   input  logic [data_width-1:0] w_data,
   input  logic [strb_width-1:0] w_strb,
   output logic                  b_valid,
   input  logic                  b_ready,
   output resp_e                 b_resp,
   output logic [id_width-1:0]   b_id,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   input  logic [addr_width-1:0] ar_addr,
   input  logic [id_width-1:0]   ar_id,
   output logic                  r_valid,
   input  logic                  r_ready,
   output logic [data_width-1:0] r_data,
   output resp_e                 r_resp,
   output logic [id_width-1:0]   r_id,
   axi_lite_if.master            bus
);

   logic                aw_hit, ar_hit;
   logic                wr_req;             // aw and w offered together
   logic                wr_acc, rd_acc;
   logic                pending;            // any response outstanding
   logic                loc_b_valid, loc_r_valid;
   logic [id_width-1:0] loc_id;

   assign aw_hit = aw_addr[addr_width-1:bram_addr_width]
                   == bram_base[addr_width-1:bram_addr_width];
   assign ar_hit = ar_addr[addr_width-1:bram_addr_width]
                   == bram_base[addr_width-1:bram_addr_width];
   assign wr_req = aw_valid && w_valid;

   // hits go on to the controller and a write wins over a same-cycle read
   assign bus.aw_valid = aw_valid && aw_hit && !pending;
   assign bus.w_valid  = w_valid && aw_hit && !pending;
   assign bus.aw_addr  = aw_addr[bram_addr_width-1:0];
   assign bus.aw_id    = aw_id;
   assign bus.w_data   = w_data;
   assign bus.w_strb   = w_strb;
   assign bus.ar_valid = ar_valid && ar_hit && !pending && !wr_req;
   assign bus.ar_addr  = ar_addr[bram_addr_width-1:0];
   assign bus.ar_id    = ar_id;
   assign bus.b_ready  = b_ready && !loc_b_valid;
   assign bus.r_ready  = r_ready && !loc_r_valid;

   // a lone aw or w is never taken
   assign aw_ready = !pending && (aw_hit ? bus.aw_ready : !(aw_valid ^ w_valid));
   assign w_ready  = !pending && (aw_hit ? bus.w_ready : !(aw_valid ^ w_valid));
   assign ar_ready = !pending && !wr_req && (ar_hit ? bus.ar_ready : 1'b1);

   assign wr_acc = wr_req && aw_ready && w_ready;
   assign rd_acc = ar_valid && ar_ready;

   always_ff @(posedge mig_clk or negedge rst_n) begin
      if (!rst_n) begin
         pending     <= 1'b0;
         loc_b_valid <= 1'b0;
         loc_r_valid <= 1'b0;
      end else begin
         if (wr_acc || rd_acc)
            pending <= 1'b1;
         else if ((b_valid && b_ready) || (r_valid && r_ready))
            pending <= 1'b0;
         if (wr_acc && !aw_hit)
            loc_b_valid <= 1'b1;
         else if (b_ready)
            loc_b_valid <= 1'b0;
         if (rd_acc && !ar_hit)
            loc_r_valid <= 1'b1;
         else if (r_ready)
            loc_r_valid <= 1'b0;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (wr_acc)
         loc_id <= aw_id;
      else if (rd_acc)
         loc_id <= ar_id;
   end

   // local decode errors take over the response channels
   assign b_valid = bus.b_valid || loc_b_valid;
   assign b_resp  = loc_b_valid ? resp_decerr : bus.b_resp;
   assign b_id    = loc_b_valid ? loc_id : bus.b_id;
   assign r_valid = bus.r_valid || loc_r_valid;
   assign r_data  = loc_r_valid ? '0 : bus.r_data;
   assign r_resp  = loc_r_valid ? resp_decerr : bus.r_resp;
   assign r_id    = loc_r_valid ? loc_id : bus.r_id;

endmodule

//--- logic/mem_pkg.sv
// bus widths, bram window defaults, response and controller state enums
package mem_pkg;

   localparam int addr_width = 32;           // physical address
   localparam int data_width = 64;
   localparam int strb_width = data_width / 8;
   localparam int id_width   = 4;

   // 4 KB on-chip block ram window at the start of dram space
   localparam int                    bram_addr_width_def = 12;
   localparam logic [addr_width-1:0] bram_base_def       = 32'h8000_0000;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_decerr = 2'b11
   } resp_e;

   typedef enum logic [1:0] {
      st_idle  = 2'b00,
      st_wresp = 2'b01,                      // b channel waiting
      st_rdata = 2'b10                       // r channel waiting
   } ctrl_state_e;

endpackage

//--- logic/ram_port_if.sv
// block ram port between controller and array
interface ram_port_if import mem_pkg::*; #(
   parameter int bram_addr_width = bram_addr_width_def
);

   logic                       en;
   logic [strb_width-1:0]      we;          // one bit per byte lane
   logic [bram_addr_width-1:0] addr;        // byte address
   logic [data_width-1:0]      wrdata;
   logic [data_width-1:0]      rddata;

   modport ctrl (
      output en, we, addr, wrdata,
      input  rddata
   );

   modport mem (
      input  en, we, addr, wrdata,
      output rddata
   );

endinterface

//--- tb.f
logic/mem_pkg.sv
logic/axi_lite_if.sv
logic/ram_port_if.sv
logic/mem_decoder.sv
logic/bram_ctrl.sv
logic/bram_array.sv
logic/chip_mem_top.sv
bench/tb_chip_mem.sv
